//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
RTL_TOP   ?= decode_stage
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- control_pkg.sv
package control_pkg;

    // {funct7[5], funct7[0], funct3}.
    typedef enum logic [4:0] {
        Add    = 5'b00000,
        Sll    = 5'b00001,
        Slt    = 5'b00010,
        Sltu   = 5'b00011,
        Xor    = 5'b00100,
        Srl    = 5'b00101,
        Or     = 5'b00110,
        And    = 5'b00111,
        Mul    = 5'b01000,
        Mulh   = 5'b01001,
        Mulhsu = 5'b01010,
        Mulhu  = 5'b01011,
        Div    = 5'b01100,
        Divu   = 5'b01101,
        Rem    = 5'b01110,
        Remu   = 5'b01111,
        Sub    = 5'b10000,
        Sra    = 5'b10101
    } alu_op_t;

    typedef enum logic [1:0] {
        WrAluY,
        WrRdData,
        WrPcPlus4,
        WrCsrRdData
    } wr_reg_t;

    // the read-modify ops take their codes from funct3[1:0].
    typedef enum logic [2:0] {
        CsrNoOp               = 3'd0,
        CsrRw                 = 3'd1,
        CsrRs                 = 3'd2,
        CsrRc                 = 3'd3,
        CsrEcall              = 3'd4,
        CsrMret               = 3'd5,
        CsrSret               = 3'd6,
        CsrIllegalInstruction = 3'd7
    } csr_op_t;

    typedef enum logic [1:0] {NoHazard, HazardDecode, HazardExecute} hazard_t;

    typedef enum logic {OnlyRs1, Rs1AndRs2} rs_used_t;

    typedef enum logic [1:0] {
        NoForward,
        ForwardDecode,
        ForwardExecute,
        ForwardExecuteMemory
    } forwarding_type_t;

    typedef enum logic [1:0] {NoBranch, CondBranch, Jump} branch_t;

    typedef enum logic [2:0] {
        Beq  = 3'b000,
        Bne  = 3'b001,
        Blt  = 3'b100,
        Bge  = 3'b101,
        Bltu = 3'b110,
        Bgeu = 3'b111
    } cond_branch_t;

endpackage

//--- control_unit.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module control_unit (
    inst_if.decoder     inst,
    ctrl_if.decoder_ctl ctrl
);
    import instruction_pkg::*;
    import control_pkg::*;

    opcode_t              opcode;
    funct3_t              funct3;
    funct7_t              funct7;
    logic [`BYTE_NUM-1:0] byte_en;

    assign opcode = opcode_t'(inst.inst[6:0]);
    assign funct3 = inst.inst[14:12];
    assign funct7 = inst.inst[31:25];

    // byte, half, word or double access.
    always_comb begin
        case (funct3[1:0])
            2'b00:   byte_en = 'h1;
            2'b01:   byte_en = 'h3;
            2'b10:   byte_en = 'hF;
            default: byte_en = 'hFF;
        endcase
    end

    always_comb begin
        ctrl.alua_src         = 1'b0;
        ctrl.alub_src         = 1'b0;
        ctrl.aluy_src         = 1'b0;
        ctrl.alu_op           = Add;
        ctrl.alupc_src        = 1'b0;
        ctrl.wr_reg_src       = WrAluY;
        ctrl.wr_reg_en        = 1'b0;
        ctrl.mem_rd_en        = 1'b0;
        ctrl.mem_wr_en        = 1'b0;
        ctrl.mem_byte_en      = '0;
        ctrl.mem_signed       = 1'b0;
        ctrl.csr_imm          = 1'b0;
        ctrl.csr_op           = CsrNoOp;
        ctrl.hazard_type      = NoHazard;
        ctrl.rs_used          = OnlyRs1;
        ctrl.forwarding_type  = NoForward;
        ctrl.branch_type      = NoBranch;
        ctrl.cond_branch_type = Beq;

        unique case (opcode)
            AluRType, AluRWType: begin
                // opcode bit 3 marks the 32-bit W forms.
                ctrl.aluy_src        = opcode[3];
                ctrl.alu_op          = alu_op_t'({funct7[5], funct7[0], funct3});
                ctrl.wr_reg_en       = 1'b1;
                ctrl.hazard_type     = HazardExecute;
                ctrl.rs_used         = Rs1AndRs2;
                ctrl.forwarding_type = ForwardExecute;
            end
            AluIType, AluIWType: begin
                ctrl.alub_src        = 1'b1;
                ctrl.aluy_src        = opcode[3];
                // only SRAI carries a funct7 bit; the rest of the upper field is immediate.
                ctrl.alu_op          = alu_op_t'({funct7[5] & (funct3 == 3'b101), 1'b0, funct3});
                ctrl.wr_reg_en       = 1'b1;
                ctrl.hazard_type     = HazardExecute;
                ctrl.forwarding_type = ForwardExecute;
            end
            LoadType: begin
                ctrl.alub_src        = 1'b1;
                ctrl.wr_reg_src      = WrRdData;
                ctrl.wr_reg_en       = 1'b1;
                ctrl.mem_rd_en       = 1'b1;
                ctrl.mem_byte_en     = byte_en;
                ctrl.mem_signed      = ~funct3[2];
                ctrl.hazard_type     = HazardExecute;
                ctrl.forwarding_type = ForwardExecute;
            end
            SType: begin
                ctrl.alub_src        = 1'b1;
                ctrl.mem_wr_en       = 1'b1;
                ctrl.mem_byte_en     = byte_en;
                ctrl.hazard_type     = HazardExecute;
                ctrl.rs_used         = Rs1AndRs2;
                ctrl.forwarding_type = ForwardExecuteMemory;
            end
            BType: begin
                ctrl.hazard_type      = HazardDecode;
                ctrl.rs_used          = Rs1AndRs2;
                ctrl.branch_type      = CondBranch;
                ctrl.cond_branch_type = cond_branch_t'(funct3);
                ctrl.forwarding_type  = ForwardDecode;
            end
            Lui: begin
                ctrl.alub_src  = 1'b1;
                ctrl.aluy_src  = 1'b1;
                ctrl.wr_reg_en = 1'b1;
            end
            Auipc: begin
                ctrl.alua_src  = 1'b1;
                ctrl.alub_src  = 1'b1;
                ctrl.wr_reg_en = 1'b1;
            end
            Jal: begin
                ctrl.wr_reg_src  = WrPcPlus4;
                ctrl.wr_reg_en   = 1'b1;
                ctrl.branch_type = Jump;
            end
            Jalr: begin
                ctrl.alupc_src       = 1'b1;
                ctrl.wr_reg_src      = WrPcPlus4;
                ctrl.wr_reg_en       = 1'b1;
                ctrl.branch_type     = Jump;
                ctrl.hazard_type     = HazardDecode;
                ctrl.forwarding_type = ForwardDecode;
            end
            // fence keeps the no-op word; ordering is handled by stalling.
            Fence: begin
            end
            SystemType: begin
                ctrl.csr_op = CsrIllegalInstruction;
                if (funct3 == 3'b000) begin
                    if (funct7 == 7'h00) begin
                        ctrl.csr_op = CsrEcall;
                    end else if ((funct7 == 7'h18 && inst.priv == Machine) ||
                                 (funct7 == 7'h08 && inst.priv inside {Machine, Supervisor})) begin
                        ctrl.csr_op = funct7[4] ? CsrMret : CsrSret;
                    end
                end else if (funct3 != 3'b100 && inst.priv >= funct7[6:5]) begin
                    ctrl.wr_reg_en       = 1'b1;
                    ctrl.wr_reg_src      = WrCsrRdData;
                    ctrl.csr_imm         = funct3[2];
                    ctrl.csr_op          = csr_op_t'(funct3[1:0]);
                    ctrl.hazard_type     = HazardExecute;
                    ctrl.forwarding_type = ForwardExecute;
                end
            end
            default: begin
                ctrl.csr_op = CsrIllegalInstruction;
            end
        endcase
    end

    a_mem_excl: assert final (!(ctrl.mem_rd_en && ctrl.mem_wr_en));

endmodule

//--- decode_if.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

interface inst_if;
    import instruction_pkg::*;

    logic                valid;
    logic [`INST_W-1:0]  inst;
    privilege_mode_t     priv;
    logic                take;

    modport producer (output valid, inst, priv, input take);
    modport decoder  (input inst, priv);
    modport consumer (input valid, output take);
endinterface

interface ctrl_if;
    import instruction_pkg::*;
    import control_pkg::*;

    logic alua_src, alub_src, aluy_src, alupc_src;
    alu_op_t alu_op;
    wr_reg_t wr_reg_src;
    logic wr_reg_en, mem_rd_en, mem_wr_en, mem_signed, csr_imm;
    logic [`BYTE_NUM-1:0] mem_byte_en;
    csr_op_t csr_op;
    hazard_t hazard_type;
    rs_used_t rs_used;
    forwarding_type_t forwarding_type;
    branch_t branch_type;
    cond_branch_t cond_branch_type;
    logic [`XLEN-1:0] imm;
    reg_idx_t rd, rs1, rs2;

    modport decoder_ctl (
        output alua_src, alub_src, aluy_src, alu_op, alupc_src, wr_reg_src, wr_reg_en,
               mem_rd_en, mem_wr_en, mem_byte_en, mem_signed, csr_imm, csr_op,
               hazard_type, rs_used, forwarding_type, branch_type, cond_branch_type
    );
    modport decoder_imm (output imm, rd, rs1, rs2);
    modport issue (
        input alua_src, alub_src, aluy_src, alu_op, alupc_src, wr_reg_src, wr_reg_en,
              mem_rd_en, mem_wr_en, mem_byte_en, mem_signed, csr_imm, csr_op,
              hazard_type, rs_used, forwarding_type, branch_type, cond_branch_type,
              imm, rd, rs1, rs2
    );
endinterface

//--- decode_issue.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module decode_issue (
    input  logic                            clk,
    input  logic                            rst_n,
    inst_if.consumer                        slot,
    ctrl_if.issue                           ctrl,
    output logic                            out_req,
    input  logic                            out_ack,
    output logic                            alua_src,
    output logic                            alub_src,
    output logic                            aluy_src,
    output control_pkg::alu_op_t            alu_op,
    output logic                            alupc_src,
    output control_pkg::wr_reg_t            wr_reg_src,
    output logic                            wr_reg_en,
    output logic                            mem_rd_en,
    output logic                            mem_wr_en,
    output logic [`BYTE_NUM-1:0]            mem_byte_en,
    output logic                            mem_signed,
    output logic                            csr_imm,
    output control_pkg::csr_op_t            csr_op,
    output control_pkg::hazard_t            hazard_type,
    output control_pkg::rs_used_t           rs_used,
    output control_pkg::forwarding_type_t   forwarding_type,
    output control_pkg::branch_t            branch_type,
    output control_pkg::cond_branch_t       cond_branch_type,
    output logic [`XLEN-1:0]                imm,
    output instruction_pkg::reg_idx_t       rd,
    output instruction_pkg::reg_idx_t       rs1,
    output instruction_pkg::reg_idx_t       rs2
);
    import control_pkg::*;

    // full stays set until the consumer has dropped its ack.
    logic full;

    assign slot.take = slot.valid && !full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_req <= 1'b0;
            full    <= 1'b0;
        end else if (slot.take) begin
            out_req <= 1'b1;
            full    <= 1'b1;
        end else begin
            if (out_req && out_ack) begin
                out_req <= 1'b0;
            end
            if (full && !out_req && !out_ack) begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alua_src         <= 1'b0;
            alub_src         <= 1'b0;
            aluy_src         <= 1'b0;
            alu_op           <= Add;
            alupc_src        <= 1'b0;
            wr_reg_src       <= WrAluY;
            wr_reg_en        <= 1'b0;
            mem_rd_en        <= 1'b0;
            mem_wr_en        <= 1'b0;
            mem_byte_en      <= '0;
            mem_signed       <= 1'b0;
            csr_imm          <= 1'b0;
            csr_op           <= CsrNoOp;
            hazard_type      <= NoHazard;
            rs_used          <= OnlyRs1;
            forwarding_type  <= NoForward;
            branch_type      <= NoBranch;
            cond_branch_type <= Beq;
            imm              <= '0;
            rd               <= '0;
            rs1              <= '0;
            rs2              <= '0;
        end else if (slot.take) begin
            alua_src         <= ctrl.alua_src;
            alub_src         <= ctrl.alub_src;
            aluy_src         <= ctrl.aluy_src;
            alu_op           <= ctrl.alu_op;
            alupc_src        <= ctrl.alupc_src;
            wr_reg_src       <= ctrl.wr_reg_src;
            wr_reg_en        <= ctrl.wr_reg_en;
            mem_rd_en        <= ctrl.mem_rd_en;
            mem_wr_en        <= ctrl.mem_wr_en;
            mem_byte_en      <= ctrl.mem_byte_en;
            mem_signed       <= ctrl.mem_signed;
            csr_imm          <= ctrl.csr_imm;
            csr_op           <= ctrl.csr_op;
            hazard_type      <= ctrl.hazard_type;
            rs_used          <= ctrl.rs_used;
            forwarding_type  <= ctrl.forwarding_type;
            branch_type      <= ctrl.branch_type;
            cond_branch_type <= ctrl.cond_branch_type;
            imm              <= ctrl.imm;
            rd               <= ctrl.rd;
            rs1              <= ctrl.rs1;
            rs2              <= ctrl.rs2;
        end
    end

    // the execute side may sample at any point of the request phase.
    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        $past(out_req) && out_req |-> $stable({imm, rd, rs1, rs2, alu_op, csr_op, mem_byte_en}));

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module decode_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_req,
    output logic                            in_ack,
    input  logic [`INST_W-1:0]              in_inst,
    input  instruction_pkg::privilege_mode_t in_priv,
    output logic                            out_req,
    input  logic                            out_ack,
    output logic                            alua_src,
    output logic                            alub_src,
    output logic                            aluy_src,
    output control_pkg::alu_op_t            alu_op,
    output logic                            alupc_src,
    output control_pkg::wr_reg_t            wr_reg_src,
    output logic                            wr_reg_en,
    output logic                            mem_rd_en,
    output logic                            mem_wr_en,
    output logic [`BYTE_NUM-1:0]            mem_byte_en,
    output logic                            mem_signed,
    output logic                            csr_imm,
    output control_pkg::csr_op_t            csr_op,
    output control_pkg::hazard_t            hazard_type,
    output control_pkg::rs_used_t           rs_used,
    output control_pkg::forwarding_type_t   forwarding_type,
    output control_pkg::branch_t            branch_type,
    output control_pkg::cond_branch_t       cond_branch_type,
    output logic [`XLEN-1:0]                imm,
    output instruction_pkg::reg_idx_t       rd,
    output instruction_pkg::reg_idx_t       rs1,
    output instruction_pkg::reg_idx_t       rs2
);
    inst_if slot ();
    ctrl_if ctrl ();

    inst_receiver u_receiver (.*);

    // both decoders work on the slot contents in parallel.
    control_unit u_control (
        .inst (slot),
        .ctrl (ctrl)
    );

    imm_gen u_imm (
        .inst (slot),
        .ctrl (ctrl)
    );

    decode_issue u_issue (.*);

endmodule

//--- imm_gen.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module imm_gen (
    inst_if.decoder     inst,
    ctrl_if.decoder_imm ctrl
);
    import instruction_pkg::*;

    logic [`INST_W-1:0] i;
    inst_fmt_t          fmt;

    assign i = inst.inst;

    always_comb begin
        case (opcode_t'(i[6:0]))
            AluIType, AluIWType, LoadType, Jalr, SystemType: fmt = FmtI;
            SType:                                            fmt = FmtS;
            BType:                                            fmt = FmtB;
            Lui, Auipc:                                       fmt = FmtU;
            Jal:                                              fmt = FmtJ;
            default:                                          fmt = FmtNone;
        endcase
    end

    // every format keeps its sign in bit 31.
    always_comb begin
        case (fmt)
            FmtI:    ctrl.imm = {{(`XLEN-12){i[31]}}, i[31:20]};
            FmtS:    ctrl.imm = {{(`XLEN-12){i[31]}}, i[31:25], i[11:7]};
            FmtB:    ctrl.imm = {{(`XLEN-13){i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            FmtU:    ctrl.imm = {{(`XLEN-32){i[31]}}, i[31:12], 12'b0};
            FmtJ:    ctrl.imm = {{(`XLEN-21){i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            default: ctrl.imm = '0;
        endcase
    end

    assign ctrl.rd  = i[11:7];
    assign ctrl.rs1 = i[19:15];
    assign ctrl.rs2 = i[24:20];

endmodule

//--- inst_receiver.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module inst_receiver (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_req,
    output logic                            in_ack,
    input  logic [`INST_W-1:0]              in_inst,
    input  instruction_pkg::privilege_mode_t in_priv,
    inst_if.producer                        slot
);
    logic capture;

    // a new request is accepted only once the previous ack has dropped and the slot is empty.
    assign capture = in_req && !in_ack && !slot.valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot.valid <= 1'b0;
            in_ack     <= 1'b0;
        end else if (capture) begin
            slot.valid <= 1'b1;
            in_ack     <= 1'b1;
        end else begin
            if (slot.take) begin
                slot.valid <= 1'b0;
            end
            if (!in_req) begin
                in_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            slot.inst <= in_inst;
            slot.priv <= in_priv;
        end
    end

    // a held item stays put until the issue side takes it.
    a_slot_hold: assert property (@(posedge clk) disable iff (!rst_n)
        slot.valid && !slot.take |=> slot.valid && $stable(slot.inst) && $stable(slot.priv));

    a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req));

endmodule

//--- instruction_pkg.sv
package instruction_pkg;

    // major opcodes of RV64I with the M extension folded into the ALU groups.
    typedef enum logic [6:0] {
        LoadType   = 7'b0000011,
        Fence      = 7'b0001111,
        AluIType   = 7'b0010011,
        Auipc      = 7'b0010111,
        AluIWType  = 7'b0011011,
        SType      = 7'b0100011,
        AluRType   = 7'b0110011,
        Lui        = 7'b0110111,
        AluRWType  = 7'b0111011,
        BType      = 7'b1100011,
        Jalr       = 7'b1100111,
        Jal        = 7'b1101111,
        SystemType = 7'b1110011
    } opcode_t;

    // encoded as the privilege bits found in CSR addresses.
    typedef enum logic [1:0] {
        User       = 2'b00,
        Supervisor = 2'b01,
        Machine    = 2'b11
    } privilege_mode_t;

    typedef enum logic [2:0] {
        FmtI,
        FmtS,
        FmtB,
        FmtU,
        FmtJ,
        FmtNone
    } inst_fmt_t;

    typedef logic [4:0] reg_idx_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

endpackage

//--- riscv_macros.svh
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// datapath width of the RV64 core.
`define XLEN 64

// one enable bit per byte of a data word.
`define BYTE_NUM 8

`define INST_W 32

`endif

//--- tb_decode_stage.sv
`timescale 1ns/1ps
`include "riscv_macros.svh"

module tb_decode_stage;
    import instruction_pkg::*;
    import control_pkg::*;

    localparam int WAIT_LIMIT = 2000;

    typedef struct packed {
        logic alua_src, alub_src, aluy_src, alupc_src;
        logic [4:0] alu_op;
        logic [1:0] wr_reg_src;
        logic wr_reg_en, mem_rd_en, mem_wr_en;
        logic [`BYTE_NUM-1:0] mem_byte_en;
        logic mem_signed, csr_imm;
        logic [2:0] csr_op;
        logic [1:0] hazard_type;
        logic rs_used;
        logic [1:0] forwarding_type, branch_type;
        logic [2:0] cond_branch_type;
        logic [`XLEN-1:0] imm;
        logic [4:0] rd, rs1, rs2;
    } exp_t;

    logic clk, rst_n, in_req, in_ack, out_req, out_ack;
    logic [`INST_W-1:0] in_inst;
    privilege_mode_t in_priv;
    logic alua_src, alub_src, aluy_src, alupc_src, wr_reg_en, mem_rd_en, mem_wr_en;
    logic mem_signed, csr_imm;
    alu_op_t alu_op;
    wr_reg_t wr_reg_src;
    logic [`BYTE_NUM-1:0] mem_byte_en;
    csr_op_t csr_op;
    hazard_t hazard_type;
    rs_used_t rs_used;
    forwarding_type_t forwarding_type;
    branch_t branch_type;
    cond_branch_t cond_branch_type;
    logic [`XLEN-1:0] imm;
    reg_idx_t rd, rs1, rs2;

    logic [`INST_W-1:0] inst_q[$];
    privilege_mode_t priv_q[$];
    bit long_delays = 0;
    logic last_ack, last_valid;

    decode_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(string name, logic [63:0] got, logic [63:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, expected);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic timeout_fail(string what);
        $display("ERRORS FOUND");
        $fatal(1, "timed out waiting for %s", what);
    endtask

    // expected control word, built from the RV64 decode rules.
    function automatic exp_t ref_decode(logic [31:0] ins, privilege_mode_t pv);
        exp_t e;
        logic [6:0] op;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [63:0] imm_i, imm_s, imm_b, imm_u, imm_j;
        e = '0;
        op = ins[6:0];
        f3 = ins[14:12];
        f7 = ins[31:25];
        e.rd = ins[11:7];
        e.rs1 = ins[19:15];
        e.rs2 = ins[24:20];
        imm_i = {{52{ins[31]}}, ins[31:20]};
        imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {{32{ins[31]}}, ins[31:12], 12'h000};
        imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        case (op)
            7'h33, 7'h3b: begin
                e.aluy_src = (op == 7'h3b);
                e.alu_op = {f7[5], f7[0], f3};
                e.wr_reg_en = 1'b1;
                e.hazard_type = HazardExecute;
                e.rs_used = Rs1AndRs2;
                e.forwarding_type = ForwardExecute;
            end
            7'h13, 7'h1b: begin
                e.alub_src = 1'b1;
                e.aluy_src = (op == 7'h1b);
                e.alu_op = {f7[5] && f3 == 3'd5, 1'b0, f3};
                e.wr_reg_en = 1'b1;
                e.hazard_type = HazardExecute;
                e.forwarding_type = ForwardExecute;
                e.imm = imm_i;
            end
            7'h03, 7'h23: begin
                e.alub_src = 1'b1;
                case (f3[1:0])
                    2'd0: e.mem_byte_en = 8'h01;
                    2'd1: e.mem_byte_en = 8'h03;
                    2'd2: e.mem_byte_en = 8'h0f;
                    default: e.mem_byte_en = 8'hff;
                endcase
                e.hazard_type = HazardExecute;
                if (op == 7'h03) begin
                    e.wr_reg_src = WrRdData;
                    e.wr_reg_en = 1'b1;
                    e.mem_rd_en = 1'b1;
                    e.mem_signed = !f3[2];
                    e.forwarding_type = ForwardExecute;
                    e.imm = imm_i;
                end else begin
                    e.mem_wr_en = 1'b1;
                    e.rs_used = Rs1AndRs2;
                    e.forwarding_type = ForwardExecuteMemory;
                    e.imm = imm_s;
                end
            end
            7'h63: begin
                e.hazard_type = HazardDecode;
                e.rs_used = Rs1AndRs2;
                e.branch_type = CondBranch;
                e.cond_branch_type = f3;
                e.forwarding_type = ForwardDecode;
                e.imm = imm_b;
            end
            7'h37, 7'h17: begin
                e.alua_src = (op == 7'h17);
                e.alub_src = 1'b1;
                e.aluy_src = (op == 7'h37);
                e.wr_reg_en = 1'b1;
                e.imm = imm_u;
            end
            7'h6f, 7'h67: begin
                e.wr_reg_src = WrPcPlus4;
                e.wr_reg_en = 1'b1;
                e.branch_type = Jump;
                e.imm = (op == 7'h6f) ? imm_j : imm_i;
                if (op == 7'h67) begin
                    e.alupc_src = 1'b1;
                    e.hazard_type = HazardDecode;
                    e.forwarding_type = ForwardDecode;
                end
            end
            7'h0f: begin
            end
            7'h73: begin
                e.imm = imm_i;
                e.csr_op = CsrIllegalInstruction;
                if (f3 == 3'd0) begin
                    if (f7 == 7'h00)
                        e.csr_op = CsrEcall;
                    else if (f7 == 7'h18 && pv == Machine)
                        e.csr_op = CsrMret;
                    else if (f7 == 7'h08 && pv != User)
                        e.csr_op = CsrSret;
                end else if (f3 != 3'd4 && 2'(pv) >= f7[6:5]) begin
                    e.wr_reg_en = 1'b1;
                    e.wr_reg_src = WrCsrRdData;
                    e.csr_imm = f3[2];
                    e.csr_op = {1'b0, f3[1:0]};
                    e.hazard_type = HazardExecute;
                    e.forwarding_type = ForwardExecute;
                end
            end
            default: e.csr_op = CsrIllegalInstruction;
        endcase
        return e;
    endfunction

    task automatic compare_outputs(exp_t e);
        check("alua_src", alua_src, e.alua_src);
        check("alub_src", alub_src, e.alub_src);
        check("aluy_src", aluy_src, e.aluy_src);
        check("alupc_src", alupc_src, e.alupc_src);
        check("alu_op", alu_op, e.alu_op);
        check("wr_reg_src", wr_reg_src, e.wr_reg_src);
        check("wr_reg_en", wr_reg_en, e.wr_reg_en);
        check("mem_rd_en", mem_rd_en, e.mem_rd_en);
        check("mem_wr_en", mem_wr_en, e.mem_wr_en);
        check("mem_byte_en", mem_byte_en, e.mem_byte_en);
        check("mem_signed", mem_signed, e.mem_signed);
        check("csr_imm", csr_imm, e.csr_imm);
        check("csr_op", csr_op, e.csr_op);
        check("hazard_type", hazard_type, e.hazard_type);
        check("rs_used", rs_used, e.rs_used);
        check("forwarding_type", forwarding_type, e.forwarding_type);
        check("branch_type", branch_type, e.branch_type);
        check("cond_branch_type", cond_branch_type, e.cond_branch_type);
        check("imm", imm, e.imm);
        check("rd", rd, e.rd);
        check("rs1", rs1, e.rs1);
        check("rs2", rs2, e.rs2);
    endtask

    task automatic send(logic [31:0] ins, privilege_mode_t pv);
        int n;
        @(posedge clk);
        #1;
        in_inst = ins;
        in_priv = pv;
        in_req = 1'b1;
        inst_q.push_back(ins);
        priv_q.push_back(pv);
        n = 0;
        while (!in_ack) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_LIMIT)
                timeout_fail("in_ack to rise");
        end
        in_req = 1'b0;
        n = 0;
        while (in_ack) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_LIMIT)
                timeout_fail("in_ack to fall");
        end
    endtask

    function automatic privilege_mode_t rand_priv();
        case ($urandom_range(0, 2))
            0: return User;
            1: return Supervisor;
            default: return Machine;
        endcase
    endfunction

    function automatic logic [31:0] rand_inst(logic [6:0] op, logic [2:0] f3);
        logic [31:0] r;
        r = $urandom;
        return {r[31:15], f3, r[11:7], op};
    endfunction

    task automatic delay_cycles();
        int d;
        d = long_delays ? $urandom_range(6, 15) : $urandom_range(0, 3);
        repeat (d) begin
            @(posedge clk);
            #1;
        end
    endtask

    // consumer side of the issue handshake, comparing each item as it appears.
    initial begin
        int n;
        exp_t e;
        forever begin
            n = 0;
            while (out_req !== 1'b1) begin
                @(posedge clk);
                #1;
                n++;
                if (n > WAIT_LIMIT)
                    timeout_fail("out_req to rise");
            end
            if (inst_q.size() == 0) begin
                $display("ERRORS FOUND");
                $fatal(1, "DUT issued an item that was never sent");
            end
            e = ref_decode(inst_q.pop_front(), priv_q.pop_front());
            compare_outputs(e);
            delay_cycles();
            out_ack = 1'b1;
            n = 0;
            while (out_req) begin
                @(posedge clk);
                #1;
                n++;
                if (n > WAIT_LIMIT)
                    timeout_fail("out_req to fall");
            end
            delay_cycles();
            out_ack = 1'b0;
        end
    end

    // a fresh ack into a slot that was already full would overwrite an item.
    always @(negedge clk) begin
        if (rst_n && in_ack && !last_ack && last_valid) begin
            $display("ERRORS FOUND");
            $fatal(1, "in_ack rose while the receive slot was full");
        end
        last_ack = in_ack;
        last_valid = dut_i.slot.valid;
    end

    initial begin
        int n;
        logic [6:0] alu_ops[4] = '{7'h33, 7'h3b, 7'h13, 7'h1b};
        logic [6:0] f7s[3] = '{7'h00, 7'h01, 7'h20};
        logic [6:0] sys_f7[5] = '{7'h00, 7'h18, 7'h08, 7'h40, 7'h7f};
        logic [31:0] ins;
        privilege_mode_t pv;
        rst_n = 1'b0;
        in_req = 1'b0;
        in_inst = '0;
        in_priv = User;
        out_ack = 1'b0;
        last_ack = 1'b0;
        last_valid = 1'b0;
        void'($urandom(32'h9040_ffc4));
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check("in_ack", in_ack, 1'b0);
        check("out_req", out_req, 1'b0);
        compare_outputs(exp_t'('0));

        for (int k = 0; k < 40; k++) begin
            ins = rand_inst(alu_ops[$urandom_range(0, 3)], 3'($urandom));
            ins[31:25] = f7s[$urandom_range(0, 2)];
            send(ins, rand_priv());
        end
        for (int f = 0; f < 8; f++) begin
            send(rand_inst(7'h03, 3'(f)), rand_priv());
            send(rand_inst(7'h23, 3'(f & 3)), rand_priv());
        end
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3)
                send(rand_inst(7'h63, 3'(f)), rand_priv());
        end
        send(rand_inst(7'h6f, 3'($urandom)), rand_priv());
        send(rand_inst(7'h67, 3'd0), rand_priv());
        send(rand_inst(7'h37, 3'($urandom)), rand_priv());
        send(rand_inst(7'h17, 3'($urandom)), rand_priv());
        send(rand_inst(7'h0f, 3'd0), rand_priv());

        for (int p = 0; p < 3; p++) begin
            pv = (p == 0) ? User : (p == 1) ? Supervisor : Machine;
            foreach (sys_f7[s]) begin
                ins = rand_inst(7'h73, 3'd0);
                ins[31:25] = sys_f7[s];
                send(ins, pv);
            end
            for (int f = 1; f < 8; f++) begin
                send(rand_inst(7'h73, 3'(f)), pv);
            end
        end
        send(rand_inst(7'h7f, 3'($urandom)), rand_priv());
        send(rand_inst(7'h00, 3'($urandom)), rand_priv());

        long_delays = 1;
        for (int k = 0; k < 12; k++) begin
            send(rand_inst(alu_ops[$urandom_range(0, 3)], 3'($urandom)), rand_priv());
        end

        n = 0;
        while (inst_q.size() != 0 || out_req || out_ack) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_LIMIT)
                timeout_fail("the last items to be issued");
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
instruction_pkg.sv
control_pkg.sv
decode_if.sv
inst_receiver.sv
control_unit.sv
imm_gen.sv
decode_issue.sv
decode_stage.sv
tb_decode_stage.sv
